// ==== Makefile ====
TOP := frame_buffer_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"

test:
	rm -f sim.log
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/frame_buffer_params.svh ====
`ifndef FRAME_BUFFER_PARAMS_SVH
`define FRAME_BUFFER_PARAMS_SVH

// stream field widths.
`define DATA_WIDTH 8
`define ID_WIDTH 4
`define DEST_WIDTH 4

`define FIFO_ADDR_WIDTH 4 // 16 entries.
`define MAX_FRAME_LEN 8
`define BEAT_CNT_WIDTH $clog2(`MAX_FRAME_LEN + 1)
`define STAT_WIDTH 16

// frame fifo behaviour, fixed for this subsystem.
`define FIFO_DROP_BAD_FRAME 1'b1
`define FIFO_DROP_WHEN_FULL 1'b1

`endif

// ==== common/frame_buffer_pkg.sv ====
`include "frame_buffer_params.svh"

package frame_buffer_pkg;

  // one byte-wide stream beat, 18 bits.
  typedef struct packed {
    logic                   user; // 1 marks a bad frame.
    logic [`DEST_WIDTH-1:0] dest;
    logic [`ID_WIDTH-1:0]   id;
    logic                   last;
    logic [`DATA_WIDTH-1:0] data;
  } beat_t;

  // one-cycle pulses from the frame fifo.
  typedef struct packed {
    logic overflow;
    logic bad_frame;
    logic good_frame;
  } fifo_status_t;

  typedef struct packed {
    logic [`STAT_WIDTH-1:0] good_count;
    logic [`STAT_WIDTH-1:0] bad_count;
    logic [`STAT_WIDTH-1:0] overflow_count;
  } frame_stats_t;

endpackage

// ==== flist.f ====
+incdir+common
common/frame_buffer_pkg.sv
rtl/beat_counter.sv
rtl/frame_len_limiter.sv
frame_fifo/frame_fifo.sv
rtl/frame_stats.sv
rtl/frame_buffer_top.sv
sim/frame_buffer_tb.sv

// ==== frame_fifo/frame_fifo.sv ====
`timescale 1ns/10ps
`include "frame_buffer_params.svh"

module frame_fifo (
  input  logic                           clk,
  input  logic                           rst,
  input  frame_buffer_pkg::beat_t        s_beat,
  input  logic                           s_valid,
  output logic                           s_ready,
  output frame_buffer_pkg::beat_t        m_beat,
  output logic                           m_valid,
  input  logic                           m_ready,
  output frame_buffer_pkg::fifo_status_t status
);

  localparam int addr_width = `FIFO_ADDR_WIDTH;
  localparam int depth      = 2 ** addr_width;

  // pointers carry an extra wrap bit.
  logic [addr_width:0] wr_ptr;       // committed.
  logic [addr_width:0] wr_ptr_next;
  logic [addr_width:0] wr_ptr_cur;   // current frame.
  logic [addr_width:0] wr_ptr_cur_next;
  logic [addr_width:0] rd_ptr;

  frame_buffer_pkg::beat_t mem [depth];

  frame_buffer_pkg::beat_t      mem_rd_data;
  logic                         mem_rd_valid;
  logic                         mem_rd_valid_next;
  frame_buffer_pkg::beat_t      out_data;
  logic                         out_valid;
  frame_buffer_pkg::fifo_status_t status_next;

  logic full_cur;
  logic full_wr;
  logic empty;
  logic write;
  logic read;
  logic out_load;
  logic drop_frame;
  logic drop_frame_next;

  assign full_cur = (wr_ptr_cur[addr_width] != rd_ptr[addr_width]) &&
                    (wr_ptr_cur[addr_width-1:0] == rd_ptr[addr_width-1:0]);
  // frame alone fills the whole memory.
  assign full_wr  = (wr_ptr[addr_width] != wr_ptr_cur[addr_width]) &&
                    (wr_ptr[addr_width-1:0] == wr_ptr_cur[addr_width-1:0]);
  assign empty    = (wr_ptr == rd_ptr);

  // oversize frames are dropped instead of stalling.
  assign s_ready = !full_cur || full_wr || `FIFO_DROP_WHEN_FULL;

  // ########################################
  // write side
  // ########################################

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame;
    status_next     = '0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame) begin
        drop_frame_next = 1'b1;
        if (s_beat.last) begin
          wr_ptr_cur_next      = wr_ptr; // rewind.
          drop_frame_next      = 1'b0;
          status_next.overflow = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (`FIFO_DROP_BAD_FRAME && s_beat.user) begin
            wr_ptr_cur_next       = wr_ptr;
            status_next.bad_frame = 1'b1;
          end else begin
            wr_ptr_next            = wr_ptr_cur + 1'b1; // commit.
            status_next.good_frame = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      status     <= '0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      status     <= status_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[addr_width-1:0]] <= s_beat;
    end
  end

  // ########################################
  // read side
  // ########################################

  always_comb begin
    read              = 1'b0;
    mem_rd_valid_next = mem_rd_valid;
    if (out_load || !mem_rd_valid) begin
      read              = !empty;
      mem_rd_valid_next = !empty;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      mem_rd_valid <= 1'b0;
    end else begin
      mem_rd_valid <= mem_rd_valid_next;
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_data <= mem[rd_ptr[addr_width-1:0]];
    end
  end

  // output register.
  assign out_load = m_ready || !out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_load) begin
      out_valid <= mem_rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= mem_rd_data;
    end
  end

  assign m_beat  = out_data;
  assign m_valid = out_valid;

  // ########################################
  // checks
  // ########################################

  one_status_pulse: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(status)
  );

  hold_while_stalled: assert property (
    @(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
  );

endmodule

// ==== rtl/beat_counter.sv ====
`timescale 1ns/10ps
`include "frame_buffer_params.svh"

module beat_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,
  input  logic                       incr,
  output logic [`BEAT_CNT_WIDTH-1:0] count,
  output logic                       at_limit
);

  // saturates at the frame limit.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (incr && (count != `MAX_FRAME_LEN)) begin
      count <= count + 1'b1;
    end
  end

  // next beat is the last one allowed.
  assign at_limit = (count == `MAX_FRAME_LEN - 1);

  // ########################################
  // checks
  // ########################################

  count_in_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= `MAX_FRAME_LEN
  );

endmodule

// ==== rtl/frame_buffer_top.sv ====
`timescale 1ns/10ps

module frame_buffer_top (
  input  logic                           clk,
  input  logic                           rst,
  input  frame_buffer_pkg::beat_t        s_beat,
  input  logic                           s_valid,
  output logic                           s_ready,
  output frame_buffer_pkg::beat_t        m_beat,
  output logic                           m_valid,
  input  logic                           m_ready,
  output frame_buffer_pkg::frame_stats_t stats
);

  frame_buffer_pkg::beat_t        lim_beat;
  logic                           lim_valid;
  logic                           lim_ready;
  frame_buffer_pkg::fifo_status_t fifo_status;

  frame_len_limiter limiter0 (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (s_beat),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .lim_beat  (lim_beat),
    .lim_valid (lim_valid),
    .lim_ready (lim_ready)
  );

  frame_fifo fifo0 (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (lim_beat),
    .s_valid (lim_valid),
    .s_ready (lim_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .status  (fifo_status)
  );

  frame_stats stats0 (
    .clk    (clk),
    .rst    (rst),
    .status (fifo_status),
    .stats  (stats)
  );

endmodule

// ==== rtl/frame_len_limiter.sv ====
`timescale 1ns/10ps
`include "frame_buffer_params.svh"

module frame_len_limiter (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_buffer_pkg::beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output frame_buffer_pkg::beat_t lim_beat,
  output logic                    lim_valid,
  input  logic                    lim_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_in_frame,
    st_discard
  } state_t;

  state_t state;
  state_t state_next;

  logic [`BEAT_CNT_WIDTH-1:0] beat_cnt;
  logic                       at_limit;
  logic                       cnt_clear;
  logic                       cnt_incr;
  logic                       pass;       // beat moves on to the fifo.
  logic                       truncate;

  beat_counter cnt0 (
    .clk      (clk),
    .rst      (rst),
    .clear    (cnt_clear),
    .incr     (cnt_incr),
    .count    (beat_cnt),
    .at_limit (at_limit)
  );

  // ########################################
  // data path
  // ########################################

  assign pass     = s_valid && lim_ready && (state != st_discard);
  assign truncate = at_limit && !s_beat.last;

  always_comb begin
    lim_beat = s_beat;
    if (truncate) begin
      lim_beat.last = 1'b1; // cut the frame here.
      lim_beat.user = 1'b1;
    end
  end

  assign lim_valid = s_valid && (state != st_discard);
  assign s_ready   = (state == st_discard) ? 1'b1 : lim_ready;

  // ########################################
  // control
  // ########################################

  always_comb begin
    state_next = state;
    cnt_clear  = 1'b0;
    cnt_incr   = 1'b0;
    if (state == st_discard) begin
      if (s_valid && s_beat.last) begin
        state_next = st_idle; // tail swallowed.
      end
    end else if (pass) begin
      if (s_beat.last) begin
        state_next = st_idle;
        cnt_clear  = 1'b1;
      end else if (truncate) begin
        state_next = st_discard;
        cnt_clear  = 1'b1;
      end else begin
        state_next = st_in_frame;
        cnt_incr   = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ########################################
  // checks
  // ########################################

  no_valid_in_discard: assert property (
    @(posedge clk) disable iff (rst)
    (state == st_discard) |-> !lim_valid
  );

  // counter must be back at zero between frames.
  idle_count_zero: assert property (
    @(posedge clk) disable iff (rst)
    (state == st_idle) |-> (beat_cnt == '0)
  );

endmodule

// ==== rtl/frame_stats.sv ====
`timescale 1ns/10ps
`include "frame_buffer_params.svh"

module frame_stats (
  input  logic                           clk,
  input  logic                           rst,
  input  frame_buffer_pkg::fifo_status_t status,
  output frame_buffer_pkg::frame_stats_t stats
);

  // increment, holding at the top value.
  function automatic logic [`STAT_WIDTH-1:0] sat_inc(
    input logic [`STAT_WIDTH-1:0] value,
    input logic                   en
  );
    if (en && (value != {`STAT_WIDTH{1'b1}})) begin
      return value + 1'b1;
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      stats <= '0;
    end else begin
      stats.good_count     <= sat_inc(stats.good_count, status.good_frame);
      stats.bad_count      <= sat_inc(stats.bad_count, status.bad_frame);
      stats.overflow_count <= sat_inc(stats.overflow_count, status.overflow);
    end
  end

endmodule

// ==== sim/frame_buffer_tb.sv ====
`timescale 1ns/10ps
`include "frame_buffer_params.svh"

module frame_buffer_tb;

  localparam int fifo_depth = 2 ** `FIFO_ADDR_WIDTH;

  logic                           clk;
  logic                           rst;
  frame_buffer_pkg::beat_t        s_beat;
  logic                           s_valid;
  logic                           s_ready;
  frame_buffer_pkg::beat_t        m_beat;
  logic                           m_valid;
  logic                           m_ready;
  frame_buffer_pkg::frame_stats_t stats;

  string       cmd_lines[$];
  int          line_count = 0;
  byte         ready_mode = "a";
  logic        draining = 1'b0;
  logic [31:0] lfsr_state = 32'd83804;

  // reference model state.
  int                             lim_cnt = 0;
  logic                           lim_discard = 1'b0;
  int                             mem_cnt = 0;   // committed beats still in memory.
  int                             pipe_cnt = 0;  // beats in the two output stages.
  logic                           fifo_drop = 1'b0;
  frame_buffer_pkg::beat_t        cur_q[$];
  frame_buffer_pkg::beat_t        exp_q[$];
  frame_buffer_pkg::frame_stats_t model_stats = '0;

  frame_buffer_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .stats   (stats)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ########################################
  // checks
  // ########################################

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare_beat(input frame_buffer_pkg::beat_t got,
                              input frame_buffer_pkg::beat_t exp);
    if (got !== exp) begin
      $display("[ERROR] m_beat: got %h, expected %h", got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_stats(input frame_buffer_pkg::frame_stats_t got,
                               input frame_buffer_pkg::frame_stats_t exp);
    if (got !== exp) begin
      $display("[ERROR] stats: good_count %h/%h, bad_count %h/%h, overflow_count %h/%h",
               got.good_count, exp.good_count, got.bad_count, exp.bad_count,
               got.overflow_count, exp.overflow_count);
      stop_with_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // ########################################
  // reference model
  // ########################################

  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic model_fifo(input frame_buffer_pkg::beat_t b);
    if (fifo_drop || (mem_cnt + cur_q.size() >= fifo_depth)) begin
      fifo_drop = 1'b1; // out of space so the rest of the frame is lost.
      if (b.last) begin
        fifo_drop = 1'b0;
        cur_q.delete();
        model_stats.overflow_count = model_stats.overflow_count + 1'b1;
      end
    end else begin
      cur_q.push_back(b);
      if (b.last && b.user) begin
        model_stats.bad_count = model_stats.bad_count + 1'b1;
        cur_q.delete();
      end else if (b.last) begin
        model_stats.good_count = model_stats.good_count + 1'b1;
        mem_cnt = mem_cnt + cur_q.size();
        while (cur_q.size() != 0) exp_q.push_back(cur_q.pop_front());
        if (ready_mode == "a") begin
          mem_cnt = 0; // drains faster than the next frame arrives.
        end
        while (pipe_cnt < 2 && mem_cnt > 0) begin
          pipe_cnt++;
          mem_cnt--;
        end
      end
    end
  endtask

  task automatic model_beat(input frame_buffer_pkg::beat_t b);
    frame_buffer_pkg::beat_t lb;
    lb = b;
    if (lim_discard) begin
      lim_discard = !b.last; // tail of a cut frame.
    end else begin
      if (lim_cnt == `MAX_FRAME_LEN - 1 && !b.last) begin
        lb.last     = 1'b1;
        lb.user     = 1'b1;
        lim_discard = 1'b1;
        lim_cnt     = 0;
      end else if (b.last) begin
        lim_cnt = 0;
      end else begin
        lim_cnt++;
      end
      model_fifo(lb);
    end
  endtask

  // ########################################
  // stimulus
  // ########################################

  // starts and ends on a falling edge.
  task automatic send_beat(input frame_buffer_pkg::beat_t b);
    logic accepted;
    accepted = 1'b0;
    s_beat   = b;
    s_valid  = 1'b1;
    while (!accepted) begin
      compare_bit("s_ready", s_ready, 1'b1); // the fifo drops instead of stalling.
      accepted = s_ready;
      @(negedge clk);
    end
    s_valid = 1'b0;
    model_beat(b);
    if (b.last) begin
      repeat (4) @(negedge clk); // gap between frames.
    end
  endtask

  task automatic drain_output();
    draining = 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    compare_bit("m_valid", m_valid, 1'b0);
    draining = 1'b0;
    mem_cnt  = 0;
    pipe_cnt = 0;
  endtask

  task automatic check_fields(input int got, input int want, input string line);
    if (got != want) begin
      $display("malformed line in the data file: %s", line);
      stop_with_failure();
    end
  endtask

  task automatic run_command(input string line);
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    int          n;
    frame_buffer_pkg::beat_t        b;
    frame_buffer_pkg::frame_stats_t file_stats;
    case (line[0])
      "B": begin
        n = $sscanf(line, "B %h %h %h %h %h", f0, f1, f2, f3, f4);
        check_fields(n, 5, line);
        b = {f2[0], f4[`DEST_WIDTH-1:0], f3[`ID_WIDTH-1:0], f1[0], f0[`DATA_WIDTH-1:0]};
        send_beat(b);
      end
      "F": begin // whole frame with user set on its last beat only.
        n = $sscanf(line, "F %h %h %h %h %h", f0, f1, f2, f3, f4);
        check_fields(n, 5, line);
        for (int i = 0; i < int'(f0); i++) begin
          b.data = f1[`DATA_WIDTH-1:0] + i[`DATA_WIDTH-1:0];
          b.last = (i == int'(f0) - 1);
          b.user = b.last && f2[0];
          b.id   = f3[`ID_WIDTH-1:0];
          b.dest = f4[`DEST_WIDTH-1:0];
          send_beat(b);
        end
      end
      "R": begin
        n = $sscanf(line, "R %c", ready_mode);
        check_fields(n, 1, line);
        if (ready_mode != "a" && ready_mode != "n" && ready_mode != "r") begin
          $display("unknown ready mode in the data file: %s", line);
          stop_with_failure();
        end
      end
      "D": drain_output();
      "E": begin
        n = $sscanf(line, "E %h %h %h", f0, f1, f2);
        check_fields(n, 3, line);
        file_stats = {f0[`STAT_WIDTH-1:0], f1[`STAT_WIDTH-1:0], f2[`STAT_WIDTH-1:0]};
        if (file_stats !== model_stats) begin
          $display("data file statistics disagree with the model: %s", line);
          stop_with_failure();
        end
        compare_stats(stats, model_stats);
      end
      default: begin
        $display("unknown command in the data file: %s", line);
        stop_with_failure();
      end
    endcase
  endtask

  // ready driver and output monitor.
  always @(negedge clk) begin
    if (!rst) begin
      if (ready_mode == "r") begin
        lfsr_state = next_lfsr(lfsr_state);
        m_ready    = lfsr_state[0];
      end else begin
        m_ready = (ready_mode == "a") || draining;
      end
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output beat %h with nothing left to receive", m_beat);
          stop_with_failure();
        end else begin
          compare_beat(m_beat, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    wait (line_count > 0);
    repeat (line_count * 200) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped making progress", line_count * 200);
    stop_with_failure();
  end

  initial begin
    int    fd;
    string line;
    rst     = 1'b1;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;
    fd = $fopen("sim/frame_buffer_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/frame_buffer_testdata.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
        cmd_lines.push_back(line);
      end
    end
    $fclose(fd);
    line_count = cmd_lines.size();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    compare_bit("m_valid", m_valid, 1'b0);
    compare_stats(stats, '0);
    foreach (cmd_lines[i]) run_command(cmd_lines[i]);
    if (exp_q.size() != 0) begin
      $display("%0d expected beats never left the DUT", exp_q.size());
      stop_with_failure();
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== sim/frame_buffer_testdata.txt ====
# B data last user id dest : one beat    F len data user id dest : frame of len beats
# R a|n|r : m_ready always/never/random   D : drain output   E good bad overflow : stats
R a
B 11 1 0 1 2
B 21 0 0 3 4
B 22 0 0 3 4
B 23 1 0 3 4
F 5 30 0 5 6
F 8 40 0 7 8
E 4 0 0
B 51 0 0 9 a
B 52 1 1 9 a
E 4 1 0
F c 60 0 b c
F 8 70 0 d e
F 2 80 1 f 0
E 5 3 0
F 9 90 0 1 1
F 7 a0 0 2 2
E 6 4 0
D
R n
F 8 b0 0 3 3
F 8 c0 0 4 4
F 4 d0 0 5 5
F 2 e0 0 6 6
F 1 f0 0 7 7
E 9 4 2
D
R r
F 6 10 0 8 8
F 7 20 0 9 9
B 31 1 0 a a
D
F 3 40 0 b b
F 2 50 1 c c
F 8 60 0 d d
D
E e 5 2
